/* vlog.f */
+incdir+tests
common/fe_mem_pkg.sv
hw/fe_itlb.sv
fe_icache/fe_icache.sv
hw/fe_fault_check.sv
hw/fe_mem.sv
tests/tb_fe_mem.sv

/* Makefile */
BIN  = obj_dir/Vtb_fe_mem
SRCS = common/fe_mem_pkg.sv hw/fe_itlb.sv fe_icache/fe_icache.sv \
       hw/fe_fault_check.sv hw/fe_mem.sv tests/fe_mem_ref.svh tests/tb_fe_mem.sv

.PHONY: all run clean

all: run

$(BIN): $(SRCS) vlog.f
	verilator --binary --assert -Wno-fatal --top-module tb_fe_mem -f vlog.f

run: $(BIN)
	./$(BIN) | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then exit 1; fi
	@grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

/* tests/fe_mem_ref.svh */
`ifndef FE_MEM_REF_SVH
`define FE_MEM_REF_SVH

// Testbench copies of the ITLB and icache contents.
logic                          ref_tlb_v     [itlb_els_lp];
logic [19:0]                   ref_tlb_vtag  [itlb_els_lp];
fe_mem_pkg::tlb_entry_s        ref_tlb_entry [itlb_els_lp];
logic                          ref_ic_v      [icache_sets_lp];
logic [19:0]                   ref_ic_tag    [icache_sets_lp];
logic [127:0]                  ref_ic_block  [icache_sets_lp];

function automatic void clear_model_tlb();
   for (int i = 0; i < itlb_els_lp; i++) begin
      ref_tlb_v[i] = 1'b0;
   end
endfunction

function automatic void clear_model_icache();
   for (int i = 0; i < icache_sets_lp; i++) begin
      ref_ic_v[i] = 1'b0;
   end
endfunction

// Same vtag overwrites its slot, a new vtag takes a free one.
function automatic void write_model_tlb(input logic [19:0] vtag,
                                        input fe_mem_pkg::tlb_entry_s entry);
   int slot;
   slot = -1;
   for (int i = 0; i < itlb_els_lp; i++) begin
      if (ref_tlb_v[i] && (ref_tlb_vtag[i] == vtag)) begin
         slot = i;
      end
   end
   for (int i = 0; i < itlb_els_lp; i++) begin
      if ((slot < 0) && !ref_tlb_v[i]) begin
         slot = i;
      end
   end
   if (slot >= 0) begin
      ref_tlb_v[slot]     = 1'b1;
      ref_tlb_vtag[slot]  = vtag;
      ref_tlb_entry[slot] = entry;
   end
endfunction

function automatic void fill_model_icache(input fe_mem_pkg::icache_fill_s f);
   int set_idx;
   set_idx = f.index % icache_sets_lp;
   ref_ic_v[set_idx]     = 1'b1;
   ref_ic_tag[set_idx]   = f.ptag;
   ref_ic_block[set_idx] = f.block;
endfunction

function automatic fe_mem_pkg::fe_mem_resp_s expected_resp(input logic [31:0] vaddr,
                                                        input fe_mem_pkg::priv_mode_e priv,
                                                        input logic trans_en);
   fe_mem_pkg::fe_mem_resp_s r;
   fe_mem_pkg::tlb_entry_s   e;
   logic                     found;
   logic                     hit;
   int                       set_idx;
   r     = '0;
   found = 1'b0;
   e     = '{ptag: vaddr[31:12], u: 1'b0, x: 1'b1};  // Passthrough.
   if (trans_en) begin
      for (int i = 0; i < itlb_els_lp; i++) begin
         if (ref_tlb_v[i] && (ref_tlb_vtag[i] == vaddr[31:12])) begin
            found = 1'b1;
            e     = ref_tlb_entry[i];
         end
      end
      if (!found) begin
         r.itlb_miss = 1'b1;
         return r;
      end
   end
   r.instr_page_fault = trans_en & (~e.x | ((priv == fe_mem_pkg::e_priv_s) & e.u)
                                         | ((priv == fe_mem_pkg::e_priv_u) & ~e.u));
   r.instr_access_fault = e.ptag[19] | e.ptag[18];
   set_idx = (vaddr >> 4) % icache_sets_lp;
   hit     = ref_ic_v[set_idx] && (ref_ic_tag[set_idx] == e.ptag);
   r.icache_miss = ~r.instr_page_fault & ~r.instr_access_fault & ~hit;
   r.data        = hit ? ref_ic_block[set_idx][vaddr[3:2]*32 +: 32] : 32'h0;
   return r;
endfunction

`endif

/* tests/tb_fe_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_fe_mem;

   localparam int itlb_els_lp    = 4;
   localparam int icache_sets_lp = 16;
   localparam int wait_limit_lp  = 16;

   logic                       clk_i;
   logic                       reset_i;
   fe_mem_pkg::fe_mem_cmd_s    mem_cmd_i;
   logic                       mem_cmd_v_i;
   logic                       mem_cmd_yumi_o;
   fe_mem_pkg::priv_mode_e     priv_i;
   logic                       translation_en_i;
   logic                       poison_i;
   logic                       fill_v_i;
   fe_mem_pkg::icache_fill_s   fill_i;
   fe_mem_pkg::fe_mem_resp_s   mem_resp_o;
   logic                       mem_resp_v_o;

   fe_mem_pkg::fe_mem_resp_s   exp_q [$];
   fe_mem_pkg::fe_mem_resp_s   exp_head;
   int                         error_count;
   int                         resp_count;
   int                         expect_count;
   int                         stall_count;
   integer                     seed;

   logic [19:0] vtag_pool [4] = '{20'h00100, 20'h00101, 20'h00102, 20'h40103};
   logic [19:0] ptag_pool [4] = '{20'h00100, 20'h00101, 20'h00555, 20'h80002};

   `include "fe_mem_ref.svh"

   fe_mem #(
      .itlb_els_p    (itlb_els_lp),
      .icache_sets_p (icache_sets_lp)
   ) i_fe_mem (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .mem_cmd_i        (mem_cmd_i),
      .mem_cmd_v_i      (mem_cmd_v_i),
      .mem_cmd_yumi_o   (mem_cmd_yumi_o),
      .priv_i           (priv_i),
      .translation_en_i (translation_en_i),
      .poison_i         (poison_i),
      .fill_v_i         (fill_v_i),
      .fill_i           (fill_i),
      .mem_resp_o       (mem_resp_o),
      .mem_resp_v_o     (mem_resp_v_o)
   );

   always #10 clk_i = ~clk_i;

   task automatic compare_field(input string name, input logic [31:0] exp_val,
                                input logic [31:0] act_val);
      assert (act_val === exp_val) else begin
         $display("Fail %0t ns: %s expected %0h got %0h", $time, name, exp_val, act_val);
         error_count++;
      end
   endtask

   // Outputs settle after the rising edge, so look at the falling one.
   always @(negedge clk_i) begin
      if (mem_resp_v_o) begin
         resp_count++;
         if (exp_q.size() == 0) begin
            $display("Error at %0t ns: response arrived with no fetch outstanding", $time);
            error_count++;
         end else begin
            exp_head = exp_q.pop_front();
            compare_field("instr_access_fault", exp_head.instr_access_fault,
                          mem_resp_o.instr_access_fault);
            compare_field("instr_page_fault", exp_head.instr_page_fault,
                          mem_resp_o.instr_page_fault);
            compare_field("itlb_miss", exp_head.itlb_miss, mem_resp_o.itlb_miss);
            compare_field("icache_miss", exp_head.icache_miss, mem_resp_o.icache_miss);
            compare_field("data", exp_head.data, mem_resp_o.data);
         end
      end
   end

   task automatic apply_cmd_to_model(input fe_mem_pkg::fe_mem_cmd_s cmd,
                                     input fe_mem_pkg::priv_mode_e priv,
                                     input logic trans_en, input logic poison);
      case (cmd.op)
         fe_mem_pkg::e_op_fetch: begin
            if (!poison) begin
               exp_q.push_back(expected_resp(cmd.vaddr, priv, trans_en));
               expect_count++;
            end
         end
         fe_mem_pkg::e_op_tlb_fill:  write_model_tlb(cmd.vaddr[31:12], cmd.entry);
         fe_mem_pkg::e_op_tlb_fence: clear_model_tlb();
         default:                    clear_model_icache();
      endcase
   endtask

   // Called on a rising edge; returns on the edge that takes the command.
   task automatic issue_cmd(input fe_mem_pkg::fe_mem_cmd_s cmd,
                            input fe_mem_pkg::priv_mode_e priv, input logic trans_en,
                            input logic poison, input logic with_fill,
                            input fe_mem_pkg::icache_fill_s fill);
      logic taken;
      logic is_fetch;
      taken       = 1'b0;
      stall_count = 0;
      is_fetch    = (cmd.op == fe_mem_pkg::e_op_fetch);
      mem_cmd_i        <= cmd;
      mem_cmd_v_i      <= 1'b1;
      priv_i           <= priv;
      translation_en_i <= trans_en;
      fill_v_i         <= with_fill;
      fill_i           <= fill;
      for (int n = 0; n <= wait_limit_lp; n++) begin
         @(negedge clk_i);
         taken = mem_cmd_yumi_o;
         if (taken) begin
            apply_cmd_to_model(cmd, priv, trans_en, poison);
         end
         if (fill_v_i) begin
            fill_model_icache(fill_i);                   // After a same-cycle fence.
         end
         @(posedge clk_i);
         fill_v_i <= 1'b0;
         poison_i <= taken & is_fetch & poison;          // Hits stage 1.
         if (taken) begin
            break;
         end
         stall_count++;
      end
      if (!taken) begin
         $display("Error at %0t ns: command not taken within %0d cycles",
                  $time, wait_limit_lp);
         error_count++;
         mem_cmd_v_i <= 1'b0;
      end
   endtask

   task automatic idle_cycles(input int count);
      mem_cmd_v_i <= 1'b0;
      repeat (count) begin
         @(posedge clk_i);
         fill_v_i <= 1'b0;
         poison_i <= 1'b0;
      end
   endtask

   task automatic send_fetch(input logic [31:0] vaddr, input fe_mem_pkg::priv_mode_e priv,
                             input logic trans_en);
      fe_mem_pkg::fe_mem_cmd_s cmd;
      cmd = '{op: fe_mem_pkg::e_op_fetch, vaddr: vaddr, entry: '0};
      issue_cmd(cmd, priv, trans_en, 1'b0, 1'b0, '0);
   endtask

   task automatic send_tlb_fill(input logic [19:0] vtag, input logic [19:0] ptag,
                                input logic u, input logic x);
      fe_mem_pkg::fe_mem_cmd_s cmd;
      cmd.op    = fe_mem_pkg::e_op_tlb_fill;
      cmd.vaddr = {vtag, 12'h000};
      cmd.entry = '{ptag: ptag, u: u, x: x};
      issue_cmd(cmd, fe_mem_pkg::e_priv_m, 1'b0, 1'b0, 1'b0, '0);
   endtask

   task automatic send_fence(input fe_mem_pkg::fe_mem_op_e op);
      fe_mem_pkg::fe_mem_cmd_s cmd;
      cmd = '{op: op, vaddr: 32'h0, entry: '0};
      issue_cmd(cmd, fe_mem_pkg::e_priv_m, 1'b0, 1'b0, 1'b0, '0);
   endtask

   task automatic fill_icache_line(input int set_idx, input logic [19:0] ptag,
                                   input logic [127:0] block);
      fe_mem_pkg::icache_fill_s f;
      f = '{index: 8'(set_idx), ptag: ptag, block: block};
      mem_cmd_v_i <= 1'b0;
      fill_v_i    <= 1'b1;
      fill_i      <= f;
      @(negedge clk_i);
      fill_model_icache(f);
      @(posedge clk_i);
      fill_v_i <= 1'b0;
      poison_i <= 1'b0;
   endtask

   task automatic check_passthrough();
      send_fetch(32'h0001_0020, fe_mem_pkg::e_priv_m, 1'b0);           // Cold miss.
      fill_icache_line(2, 20'h00010, {32'h4444_0003, 32'h3333_0002,
                                      32'h2222_0001, 32'h1111_0000});
      for (int w = 0; w < 4; w++) begin
         send_fetch(32'h0001_0020 + 4 * w, fe_mem_pkg::e_priv_m, 1'b0);
      end
      send_fetch(32'h0002_0020, fe_mem_pkg::e_priv_m, 1'b0);           // Tag mismatch.
   endtask

   task automatic check_translation();
      send_tlb_fill(20'h00040, 20'h00010, 1'b0, 1'b1);
      send_fetch(32'h0004_0024, fe_mem_pkg::e_priv_s, 1'b1);
      send_fetch(32'h0005_0024, fe_mem_pkg::e_priv_s, 1'b1);           // Unmapped.
      send_fence(fe_mem_pkg::e_op_tlb_fence);
      send_fetch(32'h0004_0024, fe_mem_pkg::e_priv_s, 1'b1);
   endtask

   task automatic check_page_faults();
      for (int ux = 0; ux < 4; ux++) begin
         send_fence(fe_mem_pkg::e_op_tlb_fence);
         send_tlb_fill(20'h00060, 20'h00010, ux[1], ux[0]);
         send_fetch(32'h0006_0038, fe_mem_pkg::e_priv_u, 1'b1);        // Set 3 still empty.
         send_fetch(32'h0006_0038, fe_mem_pkg::e_priv_s, 1'b1);
         send_fetch(32'h0006_0038, fe_mem_pkg::e_priv_m, 1'b1);
      end
   endtask

   task automatic check_access_faults();
      send_fence(fe_mem_pkg::e_op_tlb_fence);
      send_tlb_fill(20'h00070, 20'h80010, 1'b0, 1'b1);
      send_tlb_fill(20'h00071, 20'h40010, 1'b0, 1'b1);
      send_fetch(32'h0007_0020, fe_mem_pkg::e_priv_s, 1'b1);
      send_fetch(32'h0007_1020, fe_mem_pkg::e_priv_s, 1'b1);
      send_fetch(32'hC001_0020, fe_mem_pkg::e_priv_m, 1'b0);           // Passthrough.
   endtask

   task automatic check_fence_and_fill_stall();
      fe_mem_pkg::fe_mem_cmd_s  cmd;
      fe_mem_pkg::icache_fill_s f;
      send_fetch(32'h0001_0024, fe_mem_pkg::e_priv_m, 1'b0);
      send_fence(fe_mem_pkg::e_op_icache_fence);
      send_fetch(32'h0001_0024, fe_mem_pkg::e_priv_m, 1'b0);
      cmd = '{op: fe_mem_pkg::e_op_fetch, vaddr: 32'h0001_0034, entry: '0};
      f   = '{index: 8'd3, ptag: 20'h00010,
              block: {32'hdddd_0003, 32'hcccc_0002, 32'hbbbb_0001, 32'haaaa_0000}};
      issue_cmd(cmd, fe_mem_pkg::e_priv_m, 1'b0, 1'b0, 1'b1, f);
      assert (stall_count == 1) else begin
         $display("Fail %0t ns: mem_cmd_yumi_o stall cycles expected 1 got %0d",
                  $time, stall_count);
         error_count++;
      end
      send_fetch(32'h0001_0038, fe_mem_pkg::e_priv_m, 1'b0);
   endtask

   // Four pooled vtags keep the ITLB from ever replacing a live entry.
   task automatic run_random_mix(input int count);
      logic [31:0]              r;
      fe_mem_pkg::fe_mem_cmd_s  cmd;
      fe_mem_pkg::icache_fill_s f;
      fe_mem_pkg::priv_mode_e   priv;
      for (int k = 0; k < count; k++) begin
         r = $random(seed);
         case (r[7:6])
            2'd0:    priv = fe_mem_pkg::e_priv_u;
            2'd1:    priv = fe_mem_pkg::e_priv_s;
            default: priv = fe_mem_pkg::e_priv_m;
         endcase
         case (r[16:13])
            4'd10, 4'd11, 4'd12: cmd.op = fe_mem_pkg::e_op_tlb_fill;
            4'd13:               cmd.op = fe_mem_pkg::e_op_tlb_fence;
            4'd14:               cmd.op = fe_mem_pkg::e_op_icache_fence;
            default:             cmd.op = fe_mem_pkg::e_op_fetch;
         endcase
         cmd.vaddr = {vtag_pool[r[1:0]], 6'h00, r[5:2], 2'b00};   // Sets 0 to 3.
         cmd.entry = '{ptag: ptag_pool[r[9:8]], u: r[10], x: r[11] | r[12]};
         f.index   = {6'h00, r[20:19]};
         f.ptag    = ptag_pool[r[22:21]];
         for (int w = 0; w < 4; w++) begin
            f.block[w*32 +: 32] = $random(seed);
         end
         issue_cmd(cmd, priv, r[23], r[26:24] == 3'b000, r[18:17] == 2'b00, f);
         if (r[29:27] == 3'b000) begin
            idle_cycles(1);
         end
      end
   endtask

   task automatic drain_responses();
      mem_cmd_v_i <= 1'b0;
      for (int n = 0; (n < wait_limit_lp) && (exp_q.size() > 0); n++) begin
         @(posedge clk_i);
         fill_v_i <= 1'b0;
         poison_i <= 1'b0;
      end
      if (exp_q.size() > 0) begin
         $display("Error at %0t ns: %0d responses never arrived", $time, exp_q.size());
         error_count++;
      end
      idle_cycles(4);                                    // Catch stray responses.
      assert (resp_count == expect_count) else begin
         $display("Fail %0t ns: response count expected %0d got %0d",
                  $time, expect_count, resp_count);
         error_count++;
      end
   endtask

   initial begin
      seed             = 32'h8a75;
      error_count      = 0;
      resp_count       = 0;
      expect_count     = 0;
      stall_count      = 0;
      clk_i            = 1'b0;
      reset_i          = 1'b1;
      mem_cmd_i        = '0;
      mem_cmd_v_i      = 1'b0;
      priv_i           = fe_mem_pkg::e_priv_m;
      translation_en_i = 1'b0;
      poison_i         = 1'b0;
      fill_v_i         = 1'b0;
      fill_i           = '0;
      clear_model_tlb();
      clear_model_icache();
      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;
      check_passthrough();
      check_translation();
      check_page_faults();
      check_access_faults();
      check_fence_and_fill_stall();
      send_fence(fe_mem_pkg::e_op_tlb_fence);
      run_random_mix(300);
      drain_responses();
      $display("Errors: %0d, responses checked: %0d", error_count, resp_count);
      if (error_count == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/fe_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module fe_mem #(
   parameter int itlb_els_p    = 4,
   parameter int icache_sets_p = 16
) (
   input  wire logic                       clk_i,
   input  wire logic                       reset_i,
   input  wire fe_mem_pkg::fe_mem_cmd_s    mem_cmd_i,
   input  wire logic                       mem_cmd_v_i,
   output logic                            mem_cmd_yumi_o,
   input  wire fe_mem_pkg::priv_mode_e     priv_i,
   input  wire logic                       translation_en_i,
   input  wire logic                       poison_i,
   input  wire logic                       fill_v_i,
   input  wire fe_mem_pkg::icache_fill_s   fill_i,
   output fe_mem_pkg::fe_mem_resp_s        mem_resp_o,
   output logic                            mem_resp_v_o
);

   logic                                     is_fetch;
   logic                                     fetch_v;
   logic                                     tlb_fill_v;
   logic                                     tlb_fence_v;
   logic                                     icache_fence_v;

   logic                                     fetch_v_r;
   fe_mem_pkg::priv_mode_e                   priv_r;
   logic                                     trans_en_r;

   fe_mem_pkg::tlb_entry_s                   itlb_entry;
   logic                                     itlb_miss;
   logic                                     icache_hit;
   logic [fe_mem_pkg::instr_width_gp-1:0]    icache_data;
   logic                                     page_fault;
   logic                                     access_fault;
   fe_mem_pkg::fe_mem_resp_s                 resp_n;

   assign is_fetch       = (mem_cmd_i.op == fe_mem_pkg::e_op_fetch);
   assign fetch_v        = mem_cmd_v_i & is_fetch & ~fill_v_i;   // Array port busy on fill.
   assign tlb_fill_v     = mem_cmd_v_i & (mem_cmd_i.op == fe_mem_pkg::e_op_tlb_fill);
   assign tlb_fence_v    = mem_cmd_v_i & (mem_cmd_i.op == fe_mem_pkg::e_op_tlb_fence);
   assign icache_fence_v = mem_cmd_v_i & (mem_cmd_i.op == fe_mem_pkg::e_op_icache_fence);
   assign mem_cmd_yumi_o = fetch_v | tlb_fill_v | tlb_fence_v | icache_fence_v;

   always_ff @(posedge clk_i) begin
      if (fetch_v) begin
         priv_r     <= priv_i;
         trans_en_r <= translation_en_i;
      end
   end

   fe_itlb #(.els_p(itlb_els_p)) i_fe_itlb (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .flush_i          (tlb_fence_v),
      .lookup_v_i       (fetch_v),
      .vtag_i           (mem_cmd_i.vaddr[fe_mem_pkg::vaddr_width_gp-1 -: fe_mem_pkg::vtag_width_gp]),
      .translation_en_i (trans_en_r),
      .fill_v_i         (tlb_fill_v),
      .fill_vtag_i      (mem_cmd_i.vaddr[fe_mem_pkg::vaddr_width_gp-1 -: fe_mem_pkg::vtag_width_gp]),
      .fill_entry_i     (mem_cmd_i.entry),
      .entry_o          (itlb_entry),
      .miss_o           (itlb_miss)
   );

   fe_icache #(.sets_p(icache_sets_p)) i_fe_icache (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .fence_i    (icache_fence_v),
      .lookup_v_i (fetch_v),
      .vaddr_i    (mem_cmd_i.vaddr),
      .ptag_i     (itlb_entry.ptag),
      .fill_v_i   (fill_v_i),
      .fill_i     (fill_i),
      .hit_o      (icache_hit),
      .data_o     (icache_data)
   );

   fe_fault_check i_fe_fault_check (
      .entry_i          (itlb_entry),
      .priv_i           (priv_r),
      .translation_en_i (trans_en_r),
      .page_fault_o     (page_fault),
      .access_fault_o   (access_fault)
   );

   // A TLB miss masks everything else; a fault masks the cache miss.
   always_comb begin
      resp_n.itlb_miss          = itlb_miss;
      resp_n.instr_page_fault   = ~itlb_miss & page_fault;
      resp_n.instr_access_fault = ~itlb_miss & access_fault;
      resp_n.icache_miss        = ~itlb_miss & ~page_fault & ~access_fault & ~icache_hit;
      resp_n.data               = (~itlb_miss & icache_hit) ? icache_data : '0;
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         fetch_v_r    <= 1'b0;
         mem_resp_v_o <= 1'b0;
      end else begin
         fetch_v_r    <= fetch_v;
         mem_resp_v_o <= fetch_v_r & ~poison_i;         // Poison drops stage 1.
      end
   end

   always_ff @(posedge clk_i) begin
      if (fetch_v_r) begin
         mem_resp_o <= resp_n;
      end
   end

endmodule

`default_nettype wire

/* hw/fe_fault_check.sv */
`timescale 1ns/1ns
`default_nettype none

module fe_fault_check (
   input  wire fe_mem_pkg::tlb_entry_s   entry_i,
   input  wire fe_mem_pkg::priv_mode_e   priv_i,
   input  wire logic                     translation_en_i,
   output logic                          page_fault_o,
   output logic                          access_fault_o
);

   logic priv_fault;
   logic exec_fault;

   // S mode may not run user pages, U mode only runs user pages.
   always_comb begin
      priv_fault = 1'b0;
      case (priv_i)
         fe_mem_pkg::e_priv_s: priv_fault = entry_i.u;
         fe_mem_pkg::e_priv_u: priv_fault = ~entry_i.u;
         default:              priv_fault = 1'b0;      // M mode.
      endcase
   end

   assign exec_fault = ~entry_i.x;

   assign page_fault_o = translation_en_i & (priv_fault | exec_fault);

   // Top two ptag bits set is outside fetchable memory.
   assign access_fault_o = |entry_i.ptag[fe_mem_pkg::ptag_width_gp-1 -: 2];

endmodule

`default_nettype wire

/* fe_icache/fe_icache.sv */
`timescale 1ns/1ns
`default_nettype none

module fe_icache #(
   parameter int sets_p = 16
) (
   input  wire logic                                    clk_i,
   input  wire logic                                    reset_i,
   input  wire logic                                    fence_i,
   input  wire logic                                    lookup_v_i,
   input  wire logic [fe_mem_pkg::vaddr_width_gp-1:0]   vaddr_i,
   input  wire logic [fe_mem_pkg::ptag_width_gp-1:0]    ptag_i,
   input  wire logic                                    fill_v_i,
   input  wire fe_mem_pkg::icache_fill_s                fill_i,
   output logic                                         hit_o,
   output logic [fe_mem_pkg::instr_width_gp-1:0]        data_o
);

   localparam int index_width_lp    = $clog2(sets_p);
   localparam int offset_width_lp   = $clog2(fe_mem_pkg::block_width_gp / 8);
   localparam int word_sel_width_lp = offset_width_lp - 2;

   logic [sets_p-1:0]                      valid_r;
   logic [fe_mem_pkg::ptag_width_gp-1:0]   tag_mem [sets_p];
   logic [fe_mem_pkg::block_width_gp-1:0]  data_mem [sets_p];

   logic [index_width_lp-1:0]              lookup_idx;
   logic [index_width_lp-1:0]              fill_idx;

   logic                                   valid_bit_r;
   logic [fe_mem_pkg::ptag_width_gp-1:0]   tag_r;
   logic [fe_mem_pkg::block_width_gp-1:0]  block_r;
   logic [word_sel_width_lp-1:0]           word_sel_r;

   // Index sits right above the block offset, inside the page offset.
   assign lookup_idx = vaddr_i[offset_width_lp +: index_width_lp];
   assign fill_idx   = fill_i.index[index_width_lp-1:0];

   // A fill in the same cycle as a fence leaves its own set valid.
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_r <= '0;
      end else begin
         if (fence_i) begin
            valid_r <= '0;
         end
         if (fill_v_i) begin
            valid_r[fill_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         tag_mem[fill_idx]  <= fill_i.ptag;
         data_mem[fill_idx] <= fill_i.block;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         valid_bit_r <= 1'b0;
      end else if (lookup_v_i) begin
         valid_bit_r <= valid_r[lookup_idx];
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_v_i) begin
         tag_r      <= tag_mem[lookup_idx];
         block_r    <= data_mem[lookup_idx];
         word_sel_r <= vaddr_i[offset_width_lp-1:2];     // Word within block.
      end
   end

   // Stage 1 tag compare against the translated ptag.
   assign hit_o  = valid_bit_r & (tag_r == ptag_i);
   assign data_o = block_r[word_sel_r * fe_mem_pkg::instr_width_gp +: fe_mem_pkg::instr_width_gp];

endmodule

`default_nettype wire

/* hw/fe_itlb.sv */
`timescale 1ns/1ns
`default_nettype none

module fe_itlb #(
   parameter int els_p = 4
) (
   input  wire logic                                   clk_i,
   input  wire logic                                   reset_i,
   input  wire logic                                   flush_i,
   input  wire logic                                   lookup_v_i,
   input  wire logic [fe_mem_pkg::vtag_width_gp-1:0]   vtag_i,
   input  wire logic                                   translation_en_i,
   input  wire logic                                   fill_v_i,
   input  wire logic [fe_mem_pkg::vtag_width_gp-1:0]   fill_vtag_i,
   input  wire fe_mem_pkg::tlb_entry_s                 fill_entry_i,
   output fe_mem_pkg::tlb_entry_s                      entry_o,
   output logic                                        miss_o
);

   localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;

   logic [els_p-1:0]                      valid_r;
   logic [fe_mem_pkg::vtag_width_gp-1:0]  vtag_mem [els_p];
   fe_mem_pkg::tlb_entry_s                entry_mem [els_p];
   logic [ptr_width_lp-1:0]               ptr_r;

   logic                                  lookup_hit;
   fe_mem_pkg::tlb_entry_s                lookup_entry;
   logic                                  fill_hit;
   logic [ptr_width_lp-1:0]               fill_idx;

   logic                                  hit_r;
   fe_mem_pkg::tlb_entry_s                entry_r;
   logic [fe_mem_pkg::vtag_width_gp-1:0]  vtag_r;

   always_comb begin
      lookup_hit   = 1'b0;
      lookup_entry = '0;
      fill_hit     = 1'b0;
      fill_idx     = ptr_r;                              // Replace by default.
      for (int i = 0; i < els_p; i++) begin
         if (valid_r[i] && (vtag_mem[i] == vtag_i)) begin
            lookup_hit   = 1'b1;
            lookup_entry = entry_mem[i];
         end
         if (valid_r[i] && (vtag_mem[i] == fill_vtag_i)) begin
            fill_hit = 1'b1;
            fill_idx = ptr_width_lp'(i);
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
         valid_r <= '0;
      end else if (fill_v_i) begin
         valid_r[fill_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         ptr_r <= '0;
      end else if (fill_v_i && !fill_hit) begin
         ptr_r <= (ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : ptr_r + 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (fill_v_i) begin
         vtag_mem[fill_idx]  <= fill_vtag_i;
         entry_mem[fill_idx] <= fill_entry_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_v_i) begin
         hit_r   <= lookup_hit;
         entry_r <= lookup_entry;
         vtag_r  <= vtag_i;
      end
   end

   // Passthrough maps vtag to ptag as an executable supervisor page.
   assign entry_o = translation_en_i ? entry_r : '{ptag: vtag_r, u: 1'b0, x: 1'b1};
   assign miss_o  = translation_en_i & ~hit_r;

endmodule

`default_nettype wire

/* common/fe_mem_pkg.sv */
`default_nettype none

package fe_mem_pkg;

   localparam int vaddr_width_gp        = 32;
   localparam int paddr_width_gp        = 32;
   localparam int page_offset_width_gp  = 12;
   localparam int vtag_width_gp         = vaddr_width_gp - page_offset_width_gp;
   localparam int ptag_width_gp         = paddr_width_gp - page_offset_width_gp;
   localparam int instr_width_gp        = 32;
   localparam int block_width_gp        = 128;           // Four instructions.
   localparam int icache_index_width_gp = 8;             // Covers up to 256 sets.

   typedef enum logic [1:0] {
      e_op_fetch        = 2'd0,
      e_op_tlb_fill     = 2'd1,
      e_op_tlb_fence    = 2'd2,
      e_op_icache_fence = 2'd3
   } fe_mem_op_e;

   typedef enum logic [1:0] {
      e_priv_u = 2'd0,
      e_priv_s = 2'd1,
      e_priv_m = 2'd3
   } priv_mode_e;

   typedef struct packed {
      logic [ptag_width_gp-1:0] ptag;
      logic                     u;                       // User page.
      logic                     x;                       // Executable.
   } tlb_entry_s;

   // Only the vtag part of vaddr matters for a TLB fill.
   typedef struct packed {
      fe_mem_op_e                op;
      logic [vaddr_width_gp-1:0] vaddr;
      tlb_entry_s                entry;
   } fe_mem_cmd_s;

   typedef struct packed {
      logic                      instr_access_fault;
      logic                      instr_page_fault;
      logic                      itlb_miss;
      logic                      icache_miss;
      logic [instr_width_gp-1:0] data;
   } fe_mem_resp_s;

   typedef struct packed {
      logic [icache_index_width_gp-1:0] index;           // Low bits used.
      logic [ptag_width_gp-1:0]         ptag;
      logic [block_width_gp-1:0]        block;
   } icache_fill_s;

endpackage

`default_nettype wire
